/* project.f */
+incdir+hw
hw/div_pkg.sv
hw/div_decode.sv
hw/div_array.sv
hw/div_execute.sv
hw/div_result.sv
hw/approx_div_unit.sv
test/div_tb.sv

/* Bender.yml */
package:
  name: approx_div_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/div_pkg.sv
      - hw/div_decode.sv
      - hw/div_array.sv
      - hw/div_execute.sv
      - hw/div_result.sv
      - hw/approx_div_unit.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/div_tb.sv

/* test/div_tb.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module div_tb;

  localparam int KIND_NORMAL = 0;
  localparam int KIND_ZERO   = 1;
  localparam int KIND_OVF    = 2;
  localparam int D_RANGE     = 1 << `DIV_D_W;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  div_pkg::div_req_t  in_req;
  logic               out_valid;
  div_pkg::div_resp_t out_resp;

  integer            seed = 32'h0622_6758;
  div_pkg::div_req_t req_q[$];   // requests waiting for a response
  string             test_name;
  int                errors;
  int                errors_at_start;
  int                tests_run;
  int                tests_failed;
  int                run_len;
  int                max_run;
  logic              check_high;  // also check rows above the approximate ones

  approx_div_unit dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // cell level model of the restoring array plus the flag and result rules
  function automatic div_pkg::div_resp_t model_resp(input div_pkg::div_req_t req);
    div_pkg::div_resp_t  resp;
    div_pkg::divisor_t   d;
    div_pkg::quot_t      q;
    logic [`DIV_D_W-1:0] x;
    logic [`DIV_D_W-1:0] diff;
    logic [`DIV_D_W-1:0] part;
    logic                hi;
    logic                b;
    logic                b_next;
    int                  i;
    int                  j;
    d    = req.divisor;
    part = '0;
    for (i = `DIV_D_W-1; i >= 0; i--) begin
      if (i == `DIV_D_W-1) begin
        x  = req.dividend[`DIV_N_W-2 -: `DIV_D_W];
        hi = req.dividend[`DIV_N_W-1];
      end else begin
        x  = {part[`DIV_D_W-2:0], req.dividend[i]};
        hi = part[`DIV_D_W-1];
      end
      b = 1'b0;
      for (j = 0; j < `DIV_D_W; j++) begin
        if (i < `DIV_APPROX_ROWS) begin
          diff[j] = ~d[j];
          b_next  = x[j] & d[j];
        end else begin
          diff[j] = x[j] ^ d[j] ^ b;
          b_next  = (~x[j] & d[j]) | (~x[j] & b) | (d[j] & b);
        end
        b = b_next;
      end
      q[i] = hi | ~b;
      part = q[i] ? diff : x;  // keep x when the subtract fails
    end
    resp.flags.div_by_zero = (d == 0);
    resp.flags.overflow    = (d != 0) && (req.dividend[`DIV_N_W-1 -: `DIV_D_W] >= d);
    if (resp.flags.div_by_zero) begin
      resp.quot = '1;
      resp.rem  = req.dividend[`DIV_D_W-1:0];
    end else if (resp.flags.overflow) begin
      resp.quot = '1;
      resp.rem  = '0;
    end else begin
      resp.quot = q;
      resp.rem  = part;
    end
    return resp;
  endfunction

  task automatic compare_quot(input string name, input div_pkg::quot_t exp,
                              input div_pkg::quot_t act);
    if (act !== exp) begin
      $display("** Error %s: quot expected 0x%h, actual 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_rem(input string name, input div_pkg::rem_t exp,
                             input div_pkg::rem_t act);
    if (act !== exp) begin
      $display("** Error %s: rem expected 0x%h, actual 0x%h", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_flags(input string name, input div_pkg::div_flags_t exp,
                               input div_pkg::div_flags_t act);
    if (act !== exp) begin
      $display("** Error %s: flags expected %b, actual %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(input div_pkg::div_req_t req, input div_pkg::div_resp_t resp);
    div_pkg::div_resp_t exp;
    div_pkg::quot_t     mask;
    div_pkg::quot_t     exact;
    exp = model_resp(req);
    compare_quot(test_name, exp.quot, resp.quot);
    compare_rem(test_name, exp.rem, resp.rem);
    compare_flags(test_name, exp.flags, resp.flags);
    if (check_high) begin
      mask  = ~div_pkg::quot_t'((1 << `DIV_APPROX_ROWS) - 1);
      exact = div_pkg::quot_t'(req.dividend / req.divisor);
      compare_quot({test_name, " high bits"}, exact & mask, resp.quot & mask);
    end
  endtask

  // scoreboard, outputs are stable at the falling edge
  always @(negedge clk) begin
    if (out_valid === 1'b1) begin
      if (req_q.size() == 0) begin
        $display("response arrived in test %s with no request outstanding", test_name);
        errors++;
      end else begin
        check_resp(req_q.pop_front(), out_resp);
      end
      run_len++;
      if (run_len > max_run) max_run = run_len;
    end else begin
      run_len = 0;
    end
  end

  task automatic make_req(input int kind, output div_pkg::div_req_t req);
    logic [31:0] r1;
    logic [31:0] r2;
    int unsigned d_val;
    int unsigned hi_val;
    r1    = $random(seed);
    r2    = $random(seed);
    d_val = r1[`DIV_D_W-1:0];
    if (kind == KIND_ZERO) begin
      d_val  = 0;
      hi_val = r2[15:8];
    end else begin
      if (d_val == 0) d_val = 1;
      if (kind == KIND_OVF) hi_val = d_val + (r2[15:8] % (D_RANGE - d_val));
      else hi_val = r2[15:8] % d_val;  // upper byte below divisor
    end
    req.divisor  = d_val[`DIV_D_W-1:0];
    req.dividend = {hi_val[`DIV_D_W-1:0], r2[`DIV_D_W-1:0]};
  endtask

  task automatic send(input div_pkg::div_req_t req);
    @(posedge clk);
    in_valid <= 1'b1;
    in_req   <= req;
    req_q.push_back(req);
  endtask

  task automatic go_idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (req_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (req_q.size() != 0) begin
      $display("timeout in test %s, %0d responses never arrived", test_name, req_q.size());
      errors++;
      req_q.delete();
    end
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic run_reset();
    start_test("reset");
    repeat (3) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("out_valid was not low during reset");
        errors++;
      end
    end
    @(posedge clk);
    rst_n <= 1'b1;  // fourth edge still sees reset
    repeat (8) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("out_valid went high after reset with no request");
        errors++;
      end
    end
    end_test();
  endtask

  task automatic run_latency();
    div_pkg::div_req_t req;
    int                edges;
    logic              seen;
    start_test("latency");
    make_req(KIND_NORMAL, req);
    send(req);
    edges = 0;
    seen  = 1'b0;
    while (!seen && edges < 20) begin
      @(posedge clk);
      in_valid <= 1'b0;
      edges++;
      @(negedge clk);
      seen = (out_valid === 1'b1);
    end
    if (!seen) begin
      $display("no response to a single request within 20 cycles");
      errors++;
    end else if (edges != 3) begin
      $display("** Error %s: cycles expected 3, actual %0d", test_name, edges);
      errors++;
    end
    wait_drain(20);
    end_test();
  endtask

  task automatic run_kind(input string name, input int kind, input int count);
    div_pkg::div_req_t req;
    start_test(name);
    repeat (count) begin
      make_req(kind, req);
      send(req);
    end
    go_idle();
    wait_drain(50);
    end_test();
  endtask

  task automatic run_burst();
    div_pkg::div_req_t req;
    logic [31:0]       r;
    int                kind;
    start_test("burst");
    max_run = 0;
    repeat (64) begin
      r    = $random(seed);
      kind = (r[2:0] == 0) ? KIND_ZERO : (r[2:0] < 3) ? KIND_OVF : KIND_NORMAL;
      make_req(kind, req);
      send(req);
    end
    go_idle();
    wait_drain(50);
    if (max_run != 64) begin
      $display("** Error %s: run length expected 64, actual %0d", test_name, max_run);
      errors++;
    end
    end_test();
  endtask

  initial begin
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_req       = '0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    run_len      = 0;
    max_run      = 0;
    check_high   = 1'b0;
    test_name    = "init";

    run_reset();
    run_latency();
    check_high = 1'b1;
    run_kind("exact_high", KIND_NORMAL, 200);
    check_high = 1'b0;
    run_kind("div_by_zero", KIND_ZERO, 32);
    run_kind("overflow", KIND_OVF, 32);
    run_burst();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog for the whole run
  initial begin
    #100000;
    $display("simulation stopped, time limit reached");
    $display("Finished with errors");
    $finish;
  end

endmodule

/* hw/approx_div_unit.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module approx_div_unit (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_valid,
  input  div_pkg::div_req_t  in_req,
  output logic               out_valid,
  output div_pkg::div_resp_t out_resp
);

  // decode to execute
  logic                dec_valid;
  div_pkg::div_req_t   dec_req;
  div_pkg::div_flags_t dec_flags;

  // execute to result
  logic                exe_valid;
  div_pkg::div_req_t   exe_req;
  div_pkg::quot_t      exe_quot;
  div_pkg::rem_t       exe_rem;
  div_pkg::div_flags_t exe_flags;

  div_decode decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .dec_valid (dec_valid),
    .dec_req   (dec_req),
    .dec_flags (dec_flags)
  );

  div_execute execute_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_req   (dec_req),
    .dec_flags (dec_flags),
    .exe_valid (exe_valid),
    .exe_req   (exe_req),
    .exe_quot  (exe_quot),
    .exe_rem   (exe_rem),
    .exe_flags (exe_flags)
  );

  div_result result_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .exe_valid (exe_valid),
    .exe_req   (exe_req),
    .exe_quot  (exe_quot),
    .exe_rem   (exe_rem),
    .exe_flags (exe_flags),
    .out_valid (out_valid),
    .out_resp  (out_resp)
  );

endmodule

/* hw/div_result.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module div_result (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                exe_valid,
  input  div_pkg::div_req_t   exe_req,
  input  div_pkg::quot_t      exe_quot,
  input  div_pkg::rem_t       exe_rem,
  input  div_pkg::div_flags_t exe_flags,
  output logic                out_valid,
  output div_pkg::div_resp_t  out_resp
);

  div_pkg::div_resp_t resp;

  always_comb begin
    resp.flags = exe_flags;
    if (exe_flags.div_by_zero) begin
      // saturate, pass the low dividend byte back
      resp.quot = '1;
      resp.rem  = exe_req.dividend[`DIV_D_W-1:0];
    end else if (exe_flags.overflow) begin
      resp.quot = '1;
      resp.rem  = '0;
    end else begin
      resp.quot = exe_quot;  // array result as is
      resp.rem  = exe_rem;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_resp <= resp;
  end

endmodule

/* hw/div_execute.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module div_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                dec_valid,
  input  div_pkg::div_req_t   dec_req,
  input  div_pkg::div_flags_t dec_flags,
  output logic                exe_valid,
  output div_pkg::div_req_t   exe_req,
  output div_pkg::quot_t      exe_quot,
  output div_pkg::rem_t       exe_rem,
  output div_pkg::div_flags_t exe_flags
);

  div_pkg::quot_t arr_quot;
  div_pkg::rem_t  arr_rem;

  // long combinational path, kept inside this stage
  div_array array_i (
    .n (dec_req.dividend),
    .d (dec_req.divisor),
    .q (arr_quot),
    .r (arr_rem)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exe_valid <= 1'b0;
    end else begin
      exe_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    exe_req   <= dec_req;    // dividend needed later for divide by zero
    exe_flags <= dec_flags;
    exe_quot  <= arr_quot;
    exe_rem   <= arr_rem;
  end

endmodule

/* hw/div_array.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module div_array (
  input  div_pkg::dividend_t n,
  input  div_pkg::divisor_t  d,
  output div_pkg::quot_t     q,
  output div_pkg::rem_t      r
);

  // row i yields quotient bit i, row DIV_D_W-1 settles first
  logic [`DIV_D_W-1:0] x_row    [`DIV_D_W];  // minuend bits into a row
  logic [`DIV_D_W-1:0] bin_row  [`DIV_D_W];  // borrow into each cell
  logic [`DIV_D_W-1:0] diff_row [`DIV_D_W];
  logic [`DIV_D_W-1:0] bout_row [`DIV_D_W];
  logic [`DIV_D_W-1:0] part_row [`DIV_D_W];  // partial remainder out of a row
  logic [`DIV_D_W-1:0] hi_bit;               // bit left above each row

  genvar gi, gj;

  generate
    for (gi = 0; gi < `DIV_D_W; gi++) begin : g_row

      if (gi == `DIV_D_W-1) begin : g_top
        // top row sees the upper dividend bits directly
        assign x_row[gi]  = n[`DIV_N_W-2 -: `DIV_D_W];
        assign hi_bit[gi] = n[`DIV_N_W-1];
      end else begin : g_inner
        // shift previous remainder up, bring in the next dividend bit
        assign x_row[gi]  = {part_row[gi+1][`DIV_D_W-2:0], n[gi]};
        assign hi_bit[gi] = part_row[gi+1][`DIV_D_W-1];
      end

      assign bin_row[gi] = {bout_row[gi][`DIV_D_W-2:0], 1'b0};  // ripple

      // subtract succeeds if it fits or a bit was left over
      assign q[gi] = hi_bit[gi] | ~bout_row[gi][`DIV_D_W-1];

      for (gj = 0; gj < `DIV_D_W; gj++) begin : g_col
        if (gi < `DIV_APPROX_ROWS) begin : g_approx
          // cheap cell, ignores the incoming borrow
          assign diff_row[gi][gj] = ~d[gj];
          assign bout_row[gi][gj] = x_row[gi][gj] & d[gj];
        end else begin : g_exact
          assign diff_row[gi][gj] = x_row[gi][gj] ^ d[gj] ^ bin_row[gi][gj];
          assign bout_row[gi][gj] = (~x_row[gi][gj] & d[gj]) |
                                    (~(x_row[gi][gj] ^ d[gj]) & bin_row[gi][gj]);
        end

        // restore on a failed subtract
        assign part_row[gi][gj] = q[gi] ? diff_row[gi][gj] : x_row[gi][gj];
      end

    end
  endgenerate

  assign r = part_row[0];  // bottom row holds the remainder

endmodule

/* hw/div_decode.sv */
`timescale 1ns/100ps
`include "div_defs.svh"

module div_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  div_pkg::div_req_t   in_req,
  output logic                dec_valid,
  output div_pkg::div_req_t   dec_req,
  output div_pkg::div_flags_t dec_flags
);

  div_pkg::divisor_t   n_hi;    // upper dividend byte
  div_pkg::div_flags_t flags;

  assign n_hi = in_req.dividend[`DIV_N_W-1 -: `DIV_D_W];

  // the only operand comparison in the pipeline
  always_comb begin
    flags.div_by_zero = (in_req.divisor == '0);
    flags.overflow    = !flags.div_by_zero && (n_hi >= in_req.divisor);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  // payload follows every cycle, qualified by dec_valid
  always_ff @(posedge clk) begin
    dec_req   <= in_req;
    dec_flags <= flags;
  end

endmodule

/* hw/div_pkg.sv */
`include "div_defs.svh"

package div_pkg;

  typedef logic [`DIV_N_W-1:0] dividend_t;
  typedef logic [`DIV_D_W-1:0] divisor_t;
  typedef logic [`DIV_D_W-1:0] quot_t;
  typedef logic [`DIV_D_W-1:0] rem_t;

  // one request, sampled with in_valid
  typedef struct packed {
    dividend_t dividend;
    divisor_t  divisor;
  } div_req_t;

  typedef struct packed {
    logic div_by_zero;
    logic overflow;     // quotient does not fit in DIV_D_W bits
  } div_flags_t;

  // one response, valid with out_valid
  typedef struct packed {
    quot_t      quot;
    rem_t       rem;
    div_flags_t flags;
  } div_resp_t;

endpackage

/* hw/div_defs.svh */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// dividend is twice the divisor width
`define DIV_N_W 16

// divisor, quotient and remainder width
`define DIV_D_W 8

// low quotient rows built from the approximate cell
// legal range 0 to DIV_D_W, 0 gives an exact array
`define DIV_APPROX_ROWS 2

`endif
